//--- design/vproc_pkg.sv
// Vector coprocessor shared definitions
// Unit and ALU operation codes, widths and the pipe beat structs

`default_nettype none

package vproc_pkg;

    localparam int unsigned ID_W     = 3;
    localparam int unsigned OP_W     = 32;
    localparam int unsigned OP_CNT   = 2;
    localparam int unsigned UNIT_CNT = 2;

    // Execution unit selected by an instruction
    typedef enum logic [0:0] {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } op_unit;

    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01,
        ALU_AND = 2'b10,
        ALU_XOR = 2'b11
    } alu_op;

    // Control part of one input beat
    typedef struct packed {
        op_unit          unit;
        alu_op           op;
        logic [ID_W-1:0] instr_id;
        logic            first_cycle;
        logic            last_cycle;
    } pipe_ctrl_t;

    typedef struct packed {
        pipe_ctrl_t                   ctrl;
        logic [OP_CNT-1:0][OP_W-1:0]  op_data;
    } pipe_in_t;

    // Result beat whose instr_done flag marks the last beat of an instruction
    typedef struct packed {
        logic [ID_W-1:0] instr_id;
        logic [OP_W-1:0] res_data;
        logic            instr_done;
    } pipe_res_t;

endpackage

`default_nettype wire

//--- design/vproc_queue.sv
// Generic FIFO with valid/ready handshakes on both ports
// Circular buffer of DEPTH entries of type ENTRY_T

`timescale 1ns/1ps
`default_nettype none

module vproc_queue #(
    parameter int unsigned DEPTH   = 4,
    parameter type         ENTRY_T = logic
) (
    input  wire logic   clk_i,
    input  wire logic   arst_n_i,

    input  wire logic   enq_valid_i,
    output logic        enq_ready_o,
    input  wire ENTRY_T enq_data_i,

    output logic        deq_valid_o,
    input  wire logic   deq_ready_i,
    output ENTRY_T      deq_data_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    ENTRY_T           mem_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             enq;
    logic             deq;

    assign deq_valid_o = (count_q != '0);
    // A full queue still takes a beat when the head leaves in the same cycle
    assign enq_ready_o = (count_q != CNT_W'(DEPTH)) | deq_ready_i;
    assign enq         = enq_valid_i & enq_ready_o;
    assign deq         = deq_valid_o & deq_ready_i;
    assign deq_data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (enq) begin
            mem_q[wr_ptr_q] <= enq_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (enq) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (deq) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({enq, deq})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/vproc_dispatch.sv
// Input dispatch
// Steers each beat to its target unit and records the unit on first beats

`timescale 1ns/1ps
`default_nettype none

module vproc_dispatch (
    input  wire logic                               pipe_in_valid_i,
    output logic                                    pipe_in_ready_o,
    input  wire vproc_pkg::pipe_in_t                pipe_in_i,

    output logic [vproc_pkg::UNIT_CNT-1:0]          unit_in_valid_o,
    input  wire logic [vproc_pkg::UNIT_CNT-1:0]     unit_in_ready_i,

    output logic                                    uq_enq_valid_o,
    input  wire logic                               uq_enq_ready_i,
    output vproc_pkg::op_unit                       uq_enq_data_o
);

    vproc_pkg::op_unit target;

    assign target        = pipe_in_i.ctrl.unit;
    assign uq_enq_data_o = target;

    always_comb begin
        unit_in_valid_o = '0;
        uq_enq_valid_o  = 1'b0;
        pipe_in_ready_o = uq_enq_ready_i;
        if (pipe_in_valid_i) begin
            // Hold the unit back while the unit queue has no room
            unit_in_valid_o[target] = uq_enq_ready_i;
            uq_enq_valid_o          = unit_in_ready_i[target] & pipe_in_i.ctrl.first_cycle;
            pipe_in_ready_o         = uq_enq_ready_i & unit_in_ready_i[target];
        end
    end

endmodule

`default_nettype wire

//--- design/vproc_alu_unit.sv
// Single-cycle ALU unit
// Add, sub, and, xor of two operands, results buffered in a FIFO

`timescale 1ns/1ps
`default_nettype none

module vproc_alu_unit #(
    parameter int unsigned RES_QUEUE_DEPTH = 2
) (
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,

    input  wire logic                   in_valid_i,
    output logic                        in_ready_o,
    input  wire vproc_pkg::pipe_in_t    in_i,

    output logic                        out_valid_o,
    input  wire logic                   out_ready_i,
    output vproc_pkg::pipe_res_t        out_o
);

    logic [vproc_pkg::OP_W-1:0] op_a;
    logic [vproc_pkg::OP_W-1:0] op_b;
    vproc_pkg::pipe_res_t       res;

    assign op_a = in_i.op_data[0];
    assign op_b = in_i.op_data[1];

    always_comb begin
        res.instr_id   = in_i.ctrl.instr_id;
        res.instr_done = in_i.ctrl.last_cycle;
        case (in_i.ctrl.op)
            vproc_pkg::ALU_ADD: res.res_data = op_a + op_b;
            vproc_pkg::ALU_SUB: res.res_data = op_a - op_b;
            vproc_pkg::ALU_AND: res.res_data = op_a & op_b;
            default:            res.res_data = op_a ^ op_b;
        endcase
    end

    // Result buffer whose free space decides whether a new beat is taken
    vproc_queue #(
        .DEPTH       ( RES_QUEUE_DEPTH           ),
        .ENTRY_T     ( vproc_pkg::pipe_res_t     )
    ) res_queue_i (
        .clk_i       ( clk_i                     ),
        .arst_n_i    ( arst_n_i                  ),
        .enq_valid_i ( in_valid_i                ),
        .enq_ready_o ( in_ready_o                ),
        .enq_data_i  ( res                       ),
        .deq_valid_o ( out_valid_o               ),
        .deq_ready_i ( out_ready_i               ),
        .deq_data_o  ( out_o                     )
    );

endmodule

`default_nettype wire

//--- design/vproc_mul_unit.sv
// Pipelined 32-bit multiplier unit
// Two register stages, lower product bits buffered in a FIFO

`timescale 1ns/1ps
`default_nettype none

module vproc_mul_unit #(
    parameter int unsigned RES_QUEUE_DEPTH = 2
) (
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,

    input  wire logic                   in_valid_i,
    output logic                        in_ready_o,
    input  wire vproc_pkg::pipe_in_t    in_i,

    output logic                        out_valid_o,
    input  wire logic                   out_ready_i,
    output vproc_pkg::pipe_res_t        out_o
);

    // Stage 1 holds operands and tags
    logic                  s1_valid_q;
    vproc_pkg::pipe_in_t   s1_q;
    logic                  s1_ready;

    // Stage 2 holds the product
    logic                  s2_valid_q;
    vproc_pkg::pipe_res_t  s2_q;
    logic                  s2_ready;

    logic                  res_enq_ready;

    // Each stage moves on when the next one is empty or emptying
    assign s2_ready   = ~s2_valid_q | res_enq_ready;
    assign s1_ready   = ~s1_valid_q | s2_ready;
    assign in_ready_o = s1_ready;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid_q <= in_valid_i;
            end
            if (s2_ready) begin
                s2_valid_q <= s1_valid_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_ready & in_valid_i) begin
            s1_q <= in_i;
        end
        if (s2_ready & s1_valid_q) begin
            s2_q.instr_id   <= s1_q.ctrl.instr_id;
            s2_q.instr_done <= s1_q.ctrl.last_cycle;
            // Truncated to the lower OP_W bits
            s2_q.res_data   <= s1_q.op_data[0] * s1_q.op_data[1];
        end
    end

    vproc_queue #(
        .DEPTH       ( RES_QUEUE_DEPTH           ),
        .ENTRY_T     ( vproc_pkg::pipe_res_t     )
    ) res_queue_i (
        .clk_i       ( clk_i                     ),
        .arst_n_i    ( arst_n_i                  ),
        .enq_valid_i ( s2_valid_q                ),
        .enq_ready_o ( res_enq_ready             ),
        .enq_data_i  ( s2_q                      ),
        .deq_valid_o ( out_valid_o               ),
        .deq_ready_i ( out_ready_i               ),
        .deq_data_o  ( out_o                     )
    );

endmodule

`default_nettype wire

//--- design/vproc_result_mux.sv
// Result multiplexer
// Passes results of the unit at the head of the unit queue only

`timescale 1ns/1ps
`default_nettype none

module vproc_result_mux (
    input  wire logic                                           uq_deq_valid_i,
    output logic                                                uq_deq_ready_o,
    input  wire vproc_pkg::op_unit                              uq_deq_data_i,

    input  wire logic [vproc_pkg::UNIT_CNT-1:0]                 unit_out_valid_i,
    output logic [vproc_pkg::UNIT_CNT-1:0]                      unit_out_ready_o,
    input  wire vproc_pkg::pipe_res_t [vproc_pkg::UNIT_CNT-1:0] unit_out_i,

    output logic                                                pipe_out_valid_o,
    input  wire logic                                           pipe_out_ready_i,
    output vproc_pkg::pipe_res_t                                pipe_out_o
);

    always_comb begin
        pipe_out_valid_o = 1'b0;
        unit_out_ready_o = '0;
        pipe_out_o       = unit_out_i[uq_deq_data_i];
        // Nothing leaves while no instruction is outstanding
        if (uq_deq_valid_i) begin
            pipe_out_valid_o                = unit_out_valid_i[uq_deq_data_i];
            unit_out_ready_o[uq_deq_data_i] = pipe_out_ready_i;
        end
    end

    // Head entry retires with the last beat of its instruction
    assign uq_deq_ready_o = pipe_out_valid_o & pipe_out_ready_i & pipe_out_o.instr_done;

endmodule

`default_nettype wire

//--- design/vproc_unit_mux.sv
// Vector unit multiplexer top level
// Dispatches beats to ALU and MUL units and returns results in issue order

`timescale 1ns/1ps
`default_nettype none

module vproc_unit_mux #(
    parameter int unsigned UNIT_QUEUE_DEPTH = 4,
    parameter int unsigned RES_QUEUE_DEPTH  = 2
) (
    input  wire logic                   clk_i,
    input  wire logic                   arst_n_i,

    input  wire logic                   pipe_in_valid_i,
    output logic                        pipe_in_ready_o,
    input  wire vproc_pkg::pipe_in_t    pipe_in_i,

    output logic                        pipe_out_valid_o,
    input  wire logic                   pipe_out_ready_i,
    output vproc_pkg::pipe_res_t        pipe_out_o
);

    logic [vproc_pkg::UNIT_CNT-1:0]                  unit_in_valid;
    logic [vproc_pkg::UNIT_CNT-1:0]                  unit_in_ready;
    logic [vproc_pkg::UNIT_CNT-1:0]                  unit_out_valid;
    logic [vproc_pkg::UNIT_CNT-1:0]                  unit_out_ready;
    vproc_pkg::pipe_res_t [vproc_pkg::UNIT_CNT-1:0]  unit_out;

    logic                uq_enq_valid;
    logic                uq_enq_ready;
    vproc_pkg::op_unit   uq_enq_data;
    logic                uq_deq_valid;
    logic                uq_deq_ready;
    vproc_pkg::op_unit   uq_deq_data;

    vproc_dispatch dispatch_i (
        .pipe_in_valid_i ( pipe_in_valid_i ),
        .pipe_in_ready_o ( pipe_in_ready_o ),
        .pipe_in_i       ( pipe_in_i       ),
        .unit_in_valid_o ( unit_in_valid   ),
        .unit_in_ready_i ( unit_in_ready   ),
        .uq_enq_valid_o  ( uq_enq_valid    ),
        .uq_enq_ready_i  ( uq_enq_ready    ),
        .uq_enq_data_o   ( uq_enq_data     )
    );

    vproc_alu_unit #(
        .RES_QUEUE_DEPTH ( RES_QUEUE_DEPTH                     )
    ) alu_unit_i (
        .clk_i           ( clk_i                               ),
        .arst_n_i        ( arst_n_i                            ),
        .in_valid_i      ( unit_in_valid [vproc_pkg::UNIT_ALU] ),
        .in_ready_o      ( unit_in_ready [vproc_pkg::UNIT_ALU] ),
        .in_i            ( pipe_in_i                           ),
        .out_valid_o     ( unit_out_valid[vproc_pkg::UNIT_ALU] ),
        .out_ready_i     ( unit_out_ready[vproc_pkg::UNIT_ALU] ),
        .out_o           ( unit_out      [vproc_pkg::UNIT_ALU] )
    );

    vproc_mul_unit #(
        .RES_QUEUE_DEPTH ( RES_QUEUE_DEPTH                     )
    ) mul_unit_i (
        .clk_i           ( clk_i                               ),
        .arst_n_i        ( arst_n_i                            ),
        .in_valid_i      ( unit_in_valid [vproc_pkg::UNIT_MUL] ),
        .in_ready_o      ( unit_in_ready [vproc_pkg::UNIT_MUL] ),
        .in_i            ( pipe_in_i                           ),
        .out_valid_o     ( unit_out_valid[vproc_pkg::UNIT_MUL] ),
        .out_ready_i     ( unit_out_ready[vproc_pkg::UNIT_MUL] ),
        .out_o           ( unit_out      [vproc_pkg::UNIT_MUL] )
    );

    // Issue order of units, one entry per instruction
    vproc_queue #(
        .DEPTH       ( UNIT_QUEUE_DEPTH   ),
        .ENTRY_T     ( vproc_pkg::op_unit )
    ) unit_queue_i (
        .clk_i       ( clk_i              ),
        .arst_n_i    ( arst_n_i           ),
        .enq_valid_i ( uq_enq_valid       ),
        .enq_ready_o ( uq_enq_ready       ),
        .enq_data_i  ( uq_enq_data        ),
        .deq_valid_o ( uq_deq_valid       ),
        .deq_ready_i ( uq_deq_ready       ),
        .deq_data_o  ( uq_deq_data        )
    );

    vproc_result_mux result_mux_i (
        .uq_deq_valid_i   ( uq_deq_valid     ),
        .uq_deq_ready_o   ( uq_deq_ready     ),
        .uq_deq_data_i    ( uq_deq_data      ),
        .unit_out_valid_i ( unit_out_valid   ),
        .unit_out_ready_o ( unit_out_ready   ),
        .unit_out_i       ( unit_out         ),
        .pipe_out_valid_o ( pipe_out_valid_o ),
        .pipe_out_ready_i ( pipe_out_ready_i ),
        .pipe_out_o       ( pipe_out_o       )
    );

endmodule

`default_nettype wire

//--- test/vproc_unit_mux_tb.sv
// Testbench for the vector unit multiplexer
// Table-driven beats, in-order scoreboard and random output stalls

`timescale 1ns/1ps
`default_nettype none

module vproc_unit_mux_tb;

    localparam int unsigned TIMEOUT = 200;
    localparam vproc_pkg::op_unit ALU = vproc_pkg::UNIT_ALU;
    localparam vproc_pkg::op_unit MUL = vproc_pkg::UNIT_MUL;
    localparam vproc_pkg::alu_op  ADD = vproc_pkg::ALU_ADD;
    localparam vproc_pkg::alu_op  SUB = vproc_pkg::ALU_SUB;
    localparam vproc_pkg::alu_op  AND = vproc_pkg::ALU_AND;
    localparam vproc_pkg::alu_op  XOR = vproc_pkg::ALU_XOR;

    // One instruction beat with its expected result
    typedef struct packed {
        vproc_pkg::op_unit unit;
        vproc_pkg::alu_op  op;
        logic [2:0]        id;
        logic [1:0]        first_last;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       res;
    } row_t;

    logic                 clk;
    logic                 arst_n;
    logic                 in_valid;
    logic                 in_ready;
    vproc_pkg::pipe_in_t  in_beat;
    logic                 out_valid;
    logic                 out_ready;
    vproc_pkg::pipe_res_t out_beat;

    row_t                 table_q [$];
    vproc_pkg::pipe_res_t expected_q [$];
    vproc_pkg::pipe_res_t exp_beat;
    integer               seed = 4;
    int                   errors;
    int                   waited;
    logic                 stuck;

    vproc_unit_mux #(
        .UNIT_QUEUE_DEPTH ( 4         ),
        .RES_QUEUE_DEPTH  ( 2         )
    ) vproc_unit_mux_i (
        .clk_i            ( clk       ),
        .arst_n_i         ( arst_n    ),
        .pipe_in_valid_i  ( in_valid  ),
        .pipe_in_ready_o  ( in_ready  ),
        .pipe_in_i        ( in_beat   ),
        .pipe_out_valid_o ( out_valid ),
        .pipe_out_ready_i ( out_ready ),
        .pipe_out_o       ( out_beat  )
    );

    always #50 clk = ~clk;

    // Output side is ready about three cycles in four
    always @(posedge clk) begin
        #1;
        out_ready = ($random(seed) & 3) != 0;
    end

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Each row holds unit, op, id, {first, last}, operand a, operand b and the expected result
    task automatic fill_table();
        table_q.push_back({ALU, ADD, 3'd1, 2'b11, 32'h00000005, 32'h00000003, 32'h00000008});
        table_q.push_back({ALU, SUB, 3'd2, 2'b11, 32'h00000003, 32'h00000005, 32'hfffffffe});
        table_q.push_back({ALU, AND, 3'd3, 2'b11, 32'hf0f0f0f0, 32'hff00ff00, 32'hf000f000});
        table_q.push_back({ALU, XOR, 3'd4, 2'b11, 32'hf0f0f0f0, 32'hff00ff00, 32'h0ff00ff0});
        table_q.push_back({MUL, ADD, 3'd5, 2'b11, 32'h00000007, 32'h00000006, 32'h0000002a});
        table_q.push_back({MUL, ADD, 3'd6, 2'b11, 32'hffffffff, 32'hffffffff, 32'h00000001});
        table_q.push_back({MUL, ADD, 3'd7, 2'b11, 32'h12345678, 32'h00000002, 32'h2468acf0});
        // Slow MUL ahead of a fast ALU
        table_q.push_back({MUL, ADD, 3'd0, 2'b11, 32'h00010000, 32'h00010003, 32'h00030000});
        table_q.push_back({ALU, ADD, 3'd1, 2'b11, 32'hffffffff, 32'h00000002, 32'h00000001});
        // Three-beat instructions
        table_q.push_back({ALU, XOR, 3'd2, 2'b10, 32'h0000000f, 32'h000000f0, 32'h000000ff});
        table_q.push_back({ALU, XOR, 3'd2, 2'b00, 32'h12345678, 32'h12345678, 32'h00000000});
        table_q.push_back({ALU, XOR, 3'd2, 2'b01, 32'haaaaaaaa, 32'h55555555, 32'hffffffff});
        table_q.push_back({MUL, ADD, 3'd3, 2'b10, 32'h00000003, 32'h00000003, 32'h00000009});
        table_q.push_back({MUL, ADD, 3'd3, 2'b00, 32'h00000100, 32'h00000100, 32'h00010000});
        table_q.push_back({MUL, ADD, 3'd3, 2'b01, 32'h80000000, 32'h00000002, 32'h00000000});
        // Mixed burst
        table_q.push_back({MUL, ADD, 3'd4, 2'b11, 32'h00000009, 32'h00000009, 32'h00000051});
        table_q.push_back({ALU, SUB, 3'd5, 2'b11, 32'h00000010, 32'h00000001, 32'h0000000f});
        table_q.push_back({MUL, ADD, 3'd6, 2'b11, 32'h0000ffff, 32'h0000ffff, 32'hfffe0001});
        table_q.push_back({ALU, AND, 3'd7, 2'b11, 32'h12345678, 32'h0000ffff, 32'h00005678});
        table_q.push_back({MUL, ADD, 3'd0, 2'b11, 32'h11111111, 32'h0000000f, 32'hffffffff});
    endtask

    // Holds one beat on the input until it is taken
    task automatic send_beat(input row_t row, output logic timed_out);
        int                   cycles;
        vproc_pkg::pipe_res_t exp;
        cycles                   = 0;
        timed_out                = 1'b0;
        in_valid                 = 1'b1;
        in_beat.ctrl.unit        = row.unit;
        in_beat.ctrl.op          = row.op;
        in_beat.ctrl.instr_id    = row.id;
        in_beat.ctrl.first_cycle = row.first_last[1];
        in_beat.ctrl.last_cycle  = row.first_last[0];
        in_beat.op_data[0]       = row.a;
        in_beat.op_data[1]       = row.b;
        @(posedge clk);
        while (!in_ready && cycles < TIMEOUT) begin
            cycles++;
            @(posedge clk);
        end
        if (in_ready) begin
            exp.instr_id   = row.id;
            exp.res_data   = row.res;
            exp.instr_done = row.first_last[0];
            expected_q.push_back(exp);
        end else begin
            $display("Input beat with id %0d was not accepted within %0d cycles", row.id, TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end
        #1;
        in_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        if (arst_n && out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
                $display("ERROR at %0t: output beat with id %0d while none is expected",
                         $time, out_beat.instr_id);
                errors++;
            end else begin
                exp_beat = expected_q.pop_front();
                check_value("result id", out_beat.instr_id, exp_beat.instr_id);
                check_value("result data", out_beat.res_data, exp_beat.res_data);
                check_value("result done", out_beat.instr_done, exp_beat.instr_done);
            end
        end
    end

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_beat   = '0;
        out_ready = 1'b0;
        errors    = 0;
        stuck     = 1'b0;
        fill_table();
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_value("output valid after reset", out_valid, 1'b0);
        check_value("input ready after reset", in_ready, 1'b1);
        for (int i = 0; i < table_q.size() && !stuck; i++) begin
            send_beat(table_q[i], stuck);
        end
        waited = 0;
        while (expected_q.size() != 0 && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("Results are missing, %0d expected beats never came out", expected_q.size());
            errors++;
        end
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
design/vproc_pkg.sv
design/vproc_queue.sv
design/vproc_dispatch.sv
design/vproc_alu_unit.sv
design/vproc_mul_unit.sv
design/vproc_result_mux.sv
design/vproc_unit_mux.sv
test/vproc_unit_mux_tb.sv

//--- Bender.yml
package:
  name: vproc_unit_mux

sources:
  # Design, in compile order
  - design/vproc_pkg.sv
  - design/vproc_queue.sv
  - design/vproc_dispatch.sv
  - design/vproc_alu_unit.sv
  - design/vproc_mul_unit.sv
  - design/vproc_result_mux.sv
  - design/vproc_unit_mux.sv

  # Testbench
  - target: test
    files:
      - test/vproc_unit_mux_tb.sv
